/* filelist.f */
+incdir+test
source/ntm_pkg.sv
source/ntm_dot_product.sv
source/ntm_logistic_combiner.sv
source/ntm_controller.sv
source/ntm_cell_top.sv
test/ntm_cell_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass decided from the run log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module ntm_cell_tb -Mdir obj_dir -o ntm_cell_sim > build.log 2>&1 \
  && ./obj_dir/ntm_cell_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; cat sim.log; exit 1; }

/* source/ntm_cell_top.sv */
//////////////////////////////
// One controller-layer time step, Q8.8
// size_r + size_l must fit in INDEX_SIZE bits
// Row inputs only after the previous h_out_enable
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_cell_top #(
  parameter int INDEX_SIZE = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic [INDEX_SIZE-1:0] size_x,
  input  logic [INDEX_SIZE-1:0] size_r,
  input  logic [INDEX_SIZE-1:0] size_l,
  input  ntm_pkg::ntm_pair_t    x_pair,
  input  logic                  x_pair_enable,
  input  ntm_pkg::ntm_pair_t    r_pair,
  input  logic                  r_pair_enable,
  input  ntm_pkg::ntm_word_t    b_in,
  input  logic                  b_in_enable,
  output logic                  ready,
  output ntm_pkg::ntm_word_t    h_out,
  output logic                  h_out_enable
);

  import ntm_pkg::*;

  logic row_start;
  ntm_sum_t input_sum;
  ntm_sum_t memory_sum;

  // K.r pairs then U.h_prev pairs, one stream
  logic [INDEX_SIZE-1:0] memory_length;

  // Bias accepted only inside a row
  logic row_open;
  logic bias_enable;

  assign memory_length = size_r + size_l;

  //////////////////////////////
  // Row window for the bias
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_open <= 1'b0;
    end else if (row_start) begin
      row_open <= 1'b1;
    end else if (h_out_enable) begin
      row_open <= 1'b0;
    end
  end

  // Same window the engines use through their armed flag
  assign bias_enable = b_in_enable & (row_open | row_start);

  //////////////////////////////
  // Instances
  //////////////////////////////

  ntm_controller #(
    .INDEX_SIZE(INDEX_SIZE)
  ) controller (
    .CLK(CLK),
    .RST(RST),
    .start(start),
    .size_l(size_l),
    .h_out_enable(h_out_enable),
    .ready(ready),
    .row_start(row_start)
  );

  // W(l).x
  ntm_dot_product #(
    .INDEX_SIZE(INDEX_SIZE)
  ) input_dot (
    .CLK(CLK),
    .RST(RST),
    .row_start(row_start),
    .length(size_x),
    .pair(x_pair),
    .pair_enable(x_pair_enable),
    .sum(input_sum)
  );

  // K(l).r + U(l).h_prev
  ntm_dot_product #(
    .INDEX_SIZE(INDEX_SIZE)
  ) memory_dot (
    .CLK(CLK),
    .RST(RST),
    .row_start(row_start),
    .length(memory_length),
    .pair(r_pair),
    .pair_enable(r_pair_enable),
    .sum(memory_sum)
  );

  ntm_logistic_combiner combiner (
    .CLK(CLK),
    .RST(RST),
    .input_sum(input_sum),
    .memory_sum(memory_sum),
    .b_in(b_in),
    .b_in_enable(bias_enable),
    .h_out(h_out),
    .h_out_enable(h_out_enable)
  );

endmodule

`default_nettype wire

/* source/ntm_controller.sv */
//////////////////////////////
// Row sequencer for one time step
// size_l must be 1 or more
// start while running is ignored
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_controller #(
  parameter int INDEX_SIZE = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic [INDEX_SIZE-1:0] size_l,
  input  logic                  h_out_enable,
  output logic                  ready,
  output logic                  row_start
);

  //////////////////////////////
  // State
  //////////////////////////////

  localparam logic STATE_IDLE = 1'b0;
  localparam logic STATE_RUN = 1'b1;

  logic state;

  // Row bookkeeping
  logic [INDEX_SIZE-1:0] size_l_q;
  logic [INDEX_SIZE-1:0] rows_done;
  logic [INDEX_SIZE-1:0] rows_next;
  logic last_row;

  assign rows_next = rows_done + 1'b1;
  // This h_out_enable closes the final row
  assign last_row = (rows_next == size_l_q);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= STATE_IDLE;
      size_l_q <= '0;
      rows_done <= '0;
      row_start <= 1'b0;
      ready <= 1'b0;
    end else begin
      // Both outputs are single-cycle pulses
      row_start <= 1'b0;
      ready <= 1'b0;
      case (state)
        STATE_IDLE: begin
          if (start) begin
            size_l_q <= size_l;
            rows_done <= '0;
            // First row opens one cycle after start
            row_start <= 1'b1;
            state <= STATE_RUN;
          end
        end
        STATE_RUN: begin
          if (h_out_enable) begin
            rows_done <= rows_next;
            if (last_row) begin
              ready <= 1'b1;
              state <= STATE_IDLE;
            end else begin
              // Next row right behind the previous result
              row_start <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Row results only arrive while a run is open
  assert property (@(posedge CLK) disable iff (RST) h_out_enable |-> (state == STATE_RUN))
    else $error("h_out_enable while no run is open");

endmodule

`default_nettype wire

/* source/ntm_dot_product.sv */
//////////////////////////////
// Counting MAC for one row of a dot product
// length must be 1 or more, or the row never completes
// Pairs outside an armed row are dropped
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_dot_product #(
  parameter int INDEX_SIZE = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  row_start,
  input  logic [INDEX_SIZE-1:0] length,
  input  ntm_pkg::ntm_pair_t    pair,
  input  logic                  pair_enable,
  output ntm_pkg::ntm_sum_t     sum
);

  import ntm_pkg::*;

  // Row control
  logic armed;
  logic [INDEX_SIZE-1:0] count;
  logic sum_valid;

  // Datapath
  logic signed [ACC_SIZE-1:0] acc;
  ntm_word_t sum_value;

  logic active;
  logic take;
  logic last;
  logic [INDEX_SIZE-1:0] count_base;
  logic [INDEX_SIZE-1:0] count_next;
  logic signed [2*DATA_SIZE-1:0] product;
  logic signed [ACC_SIZE-1:0] acc_base;
  logic signed [ACC_SIZE-1:0] acc_next;
  logic signed [ACC_SIZE-1:0] acc_shift;

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  // A pair on the row_start cycle already counts for the new row
  assign active = armed | row_start;
  assign take = active & pair_enable;

  // Fresh row starts from zero
  assign count_base = row_start ? '0 : count;
  assign acc_base = row_start ? '0 : acc;
  assign count_next = count_base + 1'b1;
  assign last = take && (count_next == length);

  // Full-width product, no rounding before the sum
  assign product = $signed(pair.weight) * $signed(pair.operand);
  assign acc_next = acc_base + product;
  // Back to Q8.8, floor rounding
  assign acc_shift = acc_next >>> FRAC_SIZE;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      armed <= 1'b0;
      count <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= last;
      // Last pair wins over a new arm in the same cycle
      if (last) begin
        armed <= 1'b0;
      end else if (row_start) begin
        armed <= 1'b1;
      end
      if (active) begin
        count <= take ? count_next : count_base;
      end
    end
  end

  // Payload only, cleared by row_start
  always_ff @(posedge CLK) begin
    if (active) begin
      acc <= take ? acc_next : acc_base;
    end
    if (last) begin
      sum_value <= ntm_saturate(acc_shift);
    end
  end

  assign sum.value = sum_value;
  assign sum.valid = sum_valid;

  // One result per row, never a held strobe
  assert property (@(posedge CLK) disable iff (RST) sum_valid |=> !sum_valid)
    else $error("sum valid held for two cycles");

endmodule

`default_nettype wire

/* source/ntm_logistic_combiner.sv */
//////////////////////////////
// Adds both engine sums and the bias, then hard logistic
// h_out_enable comes 2 cycles after the last of the three pieces
// Each piece may arrive only once per row
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_logistic_combiner (
  input  logic               CLK,
  input  logic               RST,
  input  ntm_pkg::ntm_sum_t  input_sum,
  input  ntm_pkg::ntm_sum_t  memory_sum,
  input  ntm_pkg::ntm_word_t b_in,
  input  logic               b_in_enable,
  output ntm_pkg::ntm_word_t h_out,
  output logic               h_out_enable
);

  import ntm_pkg::*;

  // 0.5 and 1.0 in Q8.8
  localparam ntm_word_t HALF = ntm_word_t'(1 << (FRAC_SIZE - 1));
  localparam ntm_word_t ONE = ntm_word_t'(1 << FRAC_SIZE);

  // Hold registers and present flags
  ntm_word_t in_hold;
  ntm_word_t mem_hold;
  ntm_word_t b_hold;
  logic in_have;
  logic mem_have;
  logic b_have;

  // Piece either held or arriving now
  logic in_ready;
  logic mem_ready;
  logic b_ready;
  ntm_word_t in_word;
  ntm_word_t mem_word;
  ntm_word_t b_word;
  logic fire;

  logic signed [ACC_SIZE-1:0] z_wide;
  ntm_word_t z;
  logic z_valid;
  ntm_fixed_u z_view;
  logic low_sat;
  logic high_sat;
  ntm_word_t h_next;

  //////////////////////////////
  // Collect the pieces
  //////////////////////////////

  assign in_ready = in_have | input_sum.valid;
  assign mem_ready = mem_have | memory_sum.valid;
  assign b_ready = b_have | b_in_enable;

  // Bypass so the last piece needs no extra cycle
  assign in_word = input_sum.valid ? input_sum.value : in_hold;
  assign mem_word = memory_sum.valid ? memory_sum.value : mem_hold;
  assign b_word = b_in_enable ? b_in : b_hold;
  assign fire = in_ready & mem_ready & b_ready;

  // Sign extended into the wide sum
  assign z_wide = in_word + mem_word + b_word;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      in_have <= 1'b0;
      mem_have <= 1'b0;
      b_have <= 1'b0;
      z_valid <= 1'b0;
      h_out_enable <= 1'b0;
    end else begin
      z_valid <= fire;
      h_out_enable <= z_valid;
      if (fire) begin
        // Row consumed, wait for the next one
        in_have <= 1'b0;
        mem_have <= 1'b0;
        b_have <= 1'b0;
      end else begin
        if (input_sum.valid) in_have <= 1'b1;
        if (memory_sum.valid) mem_have <= 1'b1;
        if (b_in_enable) b_have <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (input_sum.valid) in_hold <= input_sum.value;
    if (memory_sum.valid) mem_hold <= memory_sum.value;
    if (b_in_enable) b_hold <= b_in;
    if (fire) z <= ntm_saturate(z_wide);
    if (z_valid) h_out <= h_next;
  end

  //////////////////////////////
  // Hard logistic
  //////////////////////////////

  assign z_view.raw = z;
  // z <= -2.0, floor integer part alone is not enough
  assign low_sat = ($signed(z_view.q.int_part) < -8'sd2) ||
                   (($signed(z_view.q.int_part) == -8'sd2) && (z_view.q.frac_part == '0));
  // z >= 2.0
  assign high_sat = $signed(z_view.q.int_part) >= 8'sd2;

  always_comb begin
    if (low_sat) begin
      h_next = '0;
    end else if (high_sat) begin
      h_next = ONE;
    end else begin
      // Slope 1/4 around 0.5
      h_next = HALF + (z_view.raw >>> 2);
    end
  end

  // Engine must not deliver twice into an unconsumed hold
  assert property (@(posedge CLK) disable iff (RST)
    !(input_sum.valid && in_have) && !(memory_sum.valid && mem_have))
    else $error("engine sum arrived while hold still present");

endmodule

`default_nettype wire

/* source/ntm_pkg.sv */
//////////////////////////////
// Shared Q8.8 word types for the controller layer
// Words are signed, 8 integer and 8 fraction bits
// Saturation helper expects a value already aligned to Q8.8
//////////////////////////////

`default_nettype none

package ntm_pkg;

  //////////////////////////////
  // Word widths
  //////////////////////////////

  // Signed data word
  localparam int DATA_SIZE = 16;
  // Fraction bits in a data word
  localparam int FRAC_SIZE = 8;
  // Full product width plus guard bits
  localparam int ACC_SIZE = 2 * DATA_SIZE + 8;

  // One Q8.8 word
  typedef logic signed [DATA_SIZE-1:0] ntm_word_t;

  // Weight and operand of one element
  typedef struct packed {
    ntm_word_t weight;
    ntm_word_t operand;
  } ntm_pair_t;

  // Same word seen raw or split at the binary point
  typedef union packed {
    ntm_word_t raw;
    struct packed {
      logic signed [DATA_SIZE-FRAC_SIZE-1:0] int_part;
      logic [FRAC_SIZE-1:0] frac_part;
    } q;
  } ntm_fixed_u;

  // Engine result, valid for one cycle
  typedef struct packed {
    ntm_word_t value;
    logic valid;
  } ntm_sum_t;

  //////////////////////////////
  // Saturation to one word
  //////////////////////////////

  function automatic ntm_word_t ntm_saturate(input logic signed [ACC_SIZE-1:0] value);
    logic [ACC_SIZE-DATA_SIZE:0] top_bits;
    top_bits = value[ACC_SIZE-1:DATA_SIZE-1];
    // All upper bits equal to the word sign means the value fits
    if ((&top_bits) || (~|top_bits)) begin
      return value[DATA_SIZE-1:0];
    end
    // Clamp toward the sign of the wide value
    if (value[ACC_SIZE-1]) begin
      return {1'b1, {(DATA_SIZE-1){1'b0}}};
    end
    return {1'b0, {(DATA_SIZE-1){1'b1}}};
  endfunction

endpackage

`default_nettype wire

/* test/ntm_cell_tb_tasks.svh */
//////////////////////////////
// Reference row model and result checks
// Included inside the testbench module body
// Reads the pair lists x_list and m_list of the includer
//////////////////////////////

`ifndef NTM_CELL_TB_TASKS_SVH
`define NTM_CELL_TB_TASKS_SVH

// Clamp any wide value into the signed 16-bit range
function automatic ntm_word_t clamp_word(input longint value);
  if (value > 32767) begin
    return 16'sh7fff;
  end
  if (value < -32768) begin
    return 16'sh8000;
  end
  return ntm_word_t'(value);
endfunction

// Expected h for one row, straight from the Q8.8 rules
function automatic ntm_word_t ntm_ref_row(input int nx, input int nm, input ntm_word_t bias);
  longint acc_x;
  longint acc_m;
  longint z_sum;
  int z;
  int i;
  acc_x = 0;
  acc_m = 0;
  for (i = 0; i < nx; i++) begin
    acc_x += longint'(x_list[i].weight) * longint'(x_list[i].operand);
  end
  for (i = 0; i < nm; i++) begin
    acc_m += longint'(m_list[i].weight) * longint'(m_list[i].operand);
  end
  // Each engine floors to Q8.8 and clamps on its own
  z_sum = longint'(clamp_word(acc_x >>> 8)) + longint'(clamp_word(acc_m >>> 8)) + longint'(bias);
  z = int'(clamp_word(z_sum));
  // Knees at -2.0 and +2.0
  if (z <= -512) begin
    return '0;
  end
  if (z >= 512) begin
    return 16'sd256;
  end
  return ntm_word_t'(128 + (z >>> 2));
endfunction

// Anything that is not a value mismatch
task automatic report_failure(input string msg);
  fail_count++;
  $display("FAILURE at %0d ns: %s", $time, msg);
  $display("sim failed");
  $fatal(1, "%s", msg);
endtask

task automatic check_word(input string what, input ntm_word_t got, input ntm_word_t exp);
  if (got !== exp) begin
    fail_count++;
    $display("ERROR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    $display("sim failed");
    $fatal(1, "%s mismatch", what);
  end
endtask

task automatic check_ready_count(input string what, input logic [INDEX_SIZE-1:0] got,
                                 input logic [INDEX_SIZE-1:0] exp);
  if (got !== exp) begin
    fail_count++;
    $display("ERROR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    $display("sim failed");
    $fatal(1, "%s mismatch", what);
  end
endtask

`endif

/* test/ntm_cell_tb.sv */
//////////////////////////////
// Testbench for one controller-layer time step
// Rows are fed only after the previous h_out_enable
// Sizes kept small so size_r + size_l fits 8 bits
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_cell_tb;

  import ntm_pkg::*;

  localparam int INDEX_SIZE = 8;
  localparam int WAIT_LIMIT = 400;

  logic CLK;
  logic RST;
  logic start;
  logic [INDEX_SIZE-1:0] size_x;
  logic [INDEX_SIZE-1:0] size_r;
  logic [INDEX_SIZE-1:0] size_l;
  ntm_pair_t x_pair;
  logic x_pair_enable;
  ntm_pair_t r_pair;
  logic r_pair_enable;
  ntm_word_t b_in;
  logic b_in_enable;
  logic ready;
  ntm_word_t h_out;
  logic h_out_enable;

  // Stimulus and scoreboard state
  integer seed = 32'hbe97_0682;
  int fail_count = 0;
  ntm_pair_t x_list [0:31];
  ntm_pair_t m_list [0:31];
  ntm_word_t exp_q [$];
  ntm_word_t exp_h;
  int h_count = 0;
  int ready_count = 0;
  int run_count = 0;
  logic [INDEX_SIZE-1:0] rows_in_run = '0;
  logic [INDEX_SIZE-1:0] expect_rows = '0;
  logic h_prev = 1'b0;

  `include "ntm_cell_tb_tasks.svh"

  ntm_cell_top #(
    .INDEX_SIZE(INDEX_SIZE)
  ) uut (
    .CLK(CLK), .RST(RST), .start(start),
    .size_x(size_x), .size_r(size_r), .size_l(size_l),
    .x_pair(x_pair), .x_pair_enable(x_pair_enable),
    .r_pair(r_pair), .r_pair_enable(r_pair_enable),
    .b_in(b_in), .b_in_enable(b_in_enable),
    .ready(ready), .h_out(h_out), .h_out_enable(h_out_enable)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic ntm_word_t rand_word(input int span);
    return ntm_word_t'($random(seed) % span);
  endfunction

  function automatic int rand_index(input int span);
    return int'($unsigned($random(seed)) % span);
  endfunction

  function automatic logic coin();
    return ($random(seed) & 1) != 0;
  endfunction

  function automatic ntm_pair_t make_pair(input int mode, input int row, input int i,
                                          input bit mem);
    ntm_word_t w;
    ntm_word_t v;
    case (mode)
      0: begin
        w = ntm_word_t'(mem ? 32 * (i + 1) : 64 * (i + 1));
        v = ntm_word_t'(mem ? 128 - 64 * i : 256 - 96 * i);
      end
      2: begin
        // 4.0 times +-4.0, far past either knee
        w = 16'sh0400;
        v = row[0] ? 16'sh0400 : -16'sh0400;
      end
      3: begin
        w = rand_word(24);
        v = rand_word(96);
      end
      4: begin
        // Full scale, x side clamps high and memory side clamps low
        w = mem ? 16'sh8000 : 16'sh7fff;
        v = 16'sh7fff;
      end
      default: begin
        w = rand_word(384);
        v = rand_word(384);
      end
    endcase
    return '{weight: w, operand: v};
  endfunction

  // One row, three streams interleaved, optional random gaps
  task automatic drive_row(input int nx, input int nm, input ntm_word_t bias, input bit gaps);
    int ix;
    int im;
    bit b_done;
    ix = 0;
    im = 0;
    b_done = 1'b0;
    while (ix < nx || im < nm || !b_done) begin
      @(posedge CLK);
      x_pair_enable <= 1'b0;
      r_pair_enable <= 1'b0;
      b_in_enable <= 1'b0;
      if (ix < nx && (!gaps || coin())) begin
        x_pair <= x_list[ix];
        x_pair_enable <= 1'b1;
        ix++;
      end
      if (im < nm && (!gaps || coin())) begin
        r_pair <= m_list[im];
        r_pair_enable <= 1'b1;
        im++;
      end
      if (!b_done && (!gaps || coin())) begin
        b_in <= bias;
        b_in_enable <= 1'b1;
        b_done = 1'b1;
      end
    end
    // Row complete, result now owed
    exp_q.push_back(ntm_ref_row(nx, nm, bias));
    @(posedge CLK);
    x_pair_enable <= 1'b0;
    r_pair_enable <= 1'b0;
    b_in_enable <= 1'b0;
  endtask

  // Strobes with no row open must be dropped
  task automatic idle_noise(input int cycles);
    int c;
    for (c = 0; c < cycles; c++) begin
      @(posedge CLK);
      x_pair <= '{weight: rand_word(32767), operand: rand_word(32767)};
      r_pair <= '{weight: rand_word(32767), operand: rand_word(32767)};
      b_in <= rand_word(32767);
      x_pair_enable <= coin();
      r_pair_enable <= coin();
      b_in_enable <= coin();
    end
    @(posedge CLK);
    x_pair_enable <= 1'b0;
    r_pair_enable <= 1'b0;
    b_in_enable <= 1'b0;
  endtask

  task automatic run_step(input int mode, input int nx, input int nr, input int nl,
                          input bit gaps);
    int row;
    int i;
    int t;
    int target;
    int nm;
    ntm_word_t bias;
    nm = nr + nl;
    run_count++;
    @(posedge CLK);
    size_x <= INDEX_SIZE'(nx);
    size_r <= INDEX_SIZE'(nr);
    size_l <= INDEX_SIZE'(nl);
    start <= 1'b1;
    expect_rows = INDEX_SIZE'(nl);
    @(posedge CLK);
    start <= 1'b0;
    for (row = 0; row < nl; row++) begin
      for (i = 0; i < nx; i++) x_list[i] = make_pair(mode, row, i, 1'b0);
      for (i = 0; i < nm; i++) m_list[i] = make_pair(mode, row, i, 1'b1);
      case (mode)
        0: bias = 16'sd40;
        2: bias = '0;
        3: bias = rand_word(32);
        4: bias = rand_word(200);
        default: bias = rand_word(256);
      endcase
      target = h_count + 1;
      drive_row(nx, nm, bias, gaps);
      t = 0;
      while (h_count < target && t < WAIT_LIMIT) begin
        @(posedge CLK);
        t++;
      end
      if (h_count < target) report_failure("timeout waiting for h_out_enable of a row");
    end
    t = 0;
    while (ready_count < run_count && t < WAIT_LIMIT) begin
      @(posedge CLK);
      t++;
    end
    if (ready_count < run_count) report_failure("timeout waiting for ready after the last row");
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  // Sampled mid-cycle, away from the driving edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (h_out_enable) begin
        if (exp_q.size() == 0) begin
          report_failure("h_out_enable before the row inputs were complete");
        end
        exp_h = exp_q.pop_front();
        check_word("h_out", h_out, exp_h);
        h_count++;
        rows_in_run++;
      end
      if (ready) begin
        if (!h_prev) report_failure("ready did not follow the last h_out_enable by one cycle");
        check_ready_count("rows before ready", rows_in_run, expect_rows);
        rows_in_run = '0;
        ready_count++;
      end
      h_prev = h_out_enable;
    end
  end

  initial begin
    RST = 1'b1;
    start = 1'b0;
    size_x = '0;
    size_r = '0;
    size_l = '0;
    x_pair = '0;
    x_pair_enable = 1'b0;
    r_pair = '0;
    r_pair_enable = 1'b0;
    b_in = '0;
    b_in_enable = 1'b0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    // Quiet after reset, compare process flags any strobe
    repeat (4) @(posedge CLK);
    run_step(0, 2, 2, 1, 1'b0);
    idle_noise(6);
    repeat (5) run_step(1, 1 + rand_index(8), 1 + rand_index(6), 1 + rand_index(4), 1'b1);
    idle_noise(4);
    run_step(2, 3, 2, 4, 1'b1);
    run_step(3, 5, 3, 3, 1'b1);
    run_step(4, 3, 1, 2, 1'b0);
    repeat (6) @(posedge CLK);
    if (exp_q.size() != 0) report_failure("rows still owed an h_out at the end");
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
